// File: sdrc_config.svh
`ifndef SDRC_CONFIG_SVH
`define SDRC_CONFIG_SVH

// --------------------
// Device geometry
`define SDR_DW          16   // Data width
`define SDR_BW          2    // Byte lanes
`define SDR_BA_W        2    // Bank address bits
`define SDR_ROW_W       12   // Row address bits
`define SDR_COL_W       8    // Column address bits
`define SDR_NBANK       4    // Banks per device

// --------------------
// Delays in clk cycles
`define SDR_TRCD        2    // ACT to RD/WR
`define SDR_TRP         2    // PRE to next command
`define SDR_TRFC        7    // REF to next command
`define SDR_TWR         2    // WR to next command
`define SDR_CAS         2    // Read latency at the pins

`define SDR_RFSH_PERIOD 390  // Cycles between refreshes
`define SDR_INIT_WAIT   100  // Power-up idle time
`define SDR_MODE_REG    12'h020  // BL1, sequential, CAS 2
`define SDR_A10         10   // Precharge-all select bit

// Commands as {cs_n, ras_n, cas_n, we_n}
`define CMD_NOP 4'b0111
`define CMD_ACT 4'b0011
`define CMD_RD  4'b0101
`define CMD_WR  4'b0100
`define CMD_PRE 4'b0010
`define CMD_REF 4'b0001
`define CMD_MRS 4'b0000

`endif

// File: sdrc_pkg.sv
`default_nettype none

`include "sdrc_config.svh"

package sdrc_pkg;

  // Word address seen by the application, bank above row above column
  typedef logic [`SDR_BA_W+`SDR_ROW_W+`SDR_COL_W-1:0] app_addr_t;

  typedef logic [`SDR_DW-1:0]    sdr_data_t;  // One device word
  typedef logic [`SDR_BW-1:0]    sdr_mask_t;  // Byte masks, active low
  typedef logic [`SDR_BA_W-1:0]  bank_t;
  typedef logic [`SDR_ROW_W-1:0] row_t;
  typedef logic [`SDR_COL_W-1:0] col_t;
  typedef logic [`SDR_ROW_W-1:0] sdr_addr_t;  // Pin address
  typedef logic [3:0]            sdr_cmd_t;   // cs_n, ras_n, cas_n, we_n

  // --------------------
  // Init and refresh sequencer
  typedef enum logic [2:0] {
    INIT_WAIT, INIT_PRE, INIT_REF1, INIT_REF2, INIT_MRS, RUN_IDLE, RUN_REF
  } init_state_e;

  // Bank scheduler
  typedef enum logic [2:0] {
    BK_IDLE, BK_PRE, BK_ACT, BK_XFR, BK_CLOSE, BK_RFSH
  } bank_state_e;

endpackage

`default_nettype wire

// File: sdrc_req_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module sdrc_req_gen import sdrc_pkg::*; (
  input  wire            clk,
  input  wire            arst_n,
  input  wire            app_req,        // Held until acked
  input  wire app_addr_t app_req_addr,
  input  wire            app_req_wr_n,   // 0 write, 1 read
  input  wire sdr_data_t app_wr_data,
  input  wire sdr_mask_t app_wr_en_n,
  input  wire            sdr_init_done,
  input  wire            b2r_ack,
  output logic           app_req_ack,
  output logic           r2b_req,
  output logic           r2b_write,
  output bank_t          r2b_ba,
  output row_t           r2b_row,
  output col_t           r2b_col,
  output sdr_data_t      r2b_wdata,
  output sdr_mask_t      r2b_mask
);

  logic req_free;  // Holding register empty or leaving now
  logic req_take;

  assign req_free = !r2b_req || b2r_ack;
  // Ack already high means this request was taken last cycle
  assign req_take = app_req && !app_req_ack && sdr_init_done && req_free;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      app_req_ack <= 1'b0;
      r2b_req     <= 1'b0;
    end else begin
      app_req_ack <= req_take;  // One-cycle pulse
      if (req_take) r2b_req <= 1'b1;
      else if (b2r_ack) r2b_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_take) begin
      r2b_write                  <= !app_req_wr_n;
      {r2b_ba, r2b_row, r2b_col} <= app_req_addr;  // Bank, row, column split
      r2b_wdata                  <= app_wr_data;
      r2b_mask                   <= app_wr_en_n;
    end
  end

endmodule

`default_nettype wire

// File: sdrc_bank_ctl.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module sdrc_bank_ctl import sdrc_pkg::*; (
  input  wire            clk,
  input  wire            arst_n,
  input  wire            r2b_req,
  input  wire            r2b_write,
  input  wire bank_t     r2b_ba,
  input  wire row_t      r2b_row,
  input  wire col_t      r2b_col,
  input  wire sdr_data_t r2b_wdata,
  input  wire sdr_mask_t r2b_mask,
  input  wire            x2c_ready,
  input  wire            rfsh_req,
  output logic           b2r_ack,
  output logic           b2x_valid,
  output sdr_cmd_t       b2x_cmd,
  output bank_t          b2x_ba,
  output sdr_addr_t      b2x_addr,
  output sdr_data_t      b2x_wdata,
  output sdr_mask_t      b2x_mask,
  output logic           rfsh_gnt
);

  bank_state_e           state, state_nxt;
  logic [`SDR_NBANK-1:0] bank_open;               // Open flag per bank
  row_t                  open_row [`SDR_NBANK];   // Row held open per bank
  logic                  cur_write;
  row_t                  cur_row;
  col_t                  cur_col;
  logic                  page_hit;
  logic                  b2x_fire;

  assign page_hit = bank_open[r2b_ba] && (open_row[r2b_ba] == r2b_row);
  assign b2x_fire = b2x_valid && x2c_ready;
  assign b2r_ack  = (state == BK_IDLE) && r2b_req && !rfsh_req;  // Refresh wins
  assign rfsh_gnt = (state == BK_RFSH);

  always_comb begin
    state_nxt = state;
    b2x_valid = 1'b0;
    b2x_cmd   = `CMD_NOP;
    b2x_addr  = '0;
    case (state)
      BK_IDLE: begin
        if (rfsh_req) state_nxt = (|bank_open) ? BK_CLOSE : BK_RFSH;
        else if (r2b_req) begin
          if (page_hit) state_nxt = BK_XFR;
          else state_nxt = bank_open[r2b_ba] ? BK_PRE : BK_ACT;  // Miss or closed
        end
      end
      BK_PRE: begin
        b2x_valid = 1'b1;
        b2x_cmd   = `CMD_PRE;  // Single bank, A10 low
        if (b2x_fire) state_nxt = BK_ACT;
      end
      BK_ACT: begin
        b2x_valid = 1'b1;
        b2x_cmd   = `CMD_ACT;
        b2x_addr  = cur_row;
        if (b2x_fire) state_nxt = BK_XFR;
      end
      BK_XFR: begin
        b2x_valid = 1'b1;
        b2x_cmd   = cur_write ? `CMD_WR : `CMD_RD;
        b2x_addr  = sdr_addr_t'(cur_col);  // No auto-precharge
        if (b2x_fire) state_nxt = BK_IDLE;
      end
      BK_CLOSE: begin
        b2x_valid           = 1'b1;
        b2x_cmd             = `CMD_PRE;
        b2x_addr[`SDR_A10]  = 1'b1;  // All banks
        if (b2x_fire) state_nxt = BK_RFSH;
      end
      BK_RFSH: if (!rfsh_req) state_nxt = BK_IDLE;  // Hold grant until REF done
      default: state_nxt = BK_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= BK_IDLE;
      bank_open <= '0;
    end else begin
      state <= state_nxt;
      if (b2x_fire && state == BK_PRE) bank_open[b2x_ba] <= 1'b0;
      if (b2x_fire && state == BK_ACT) bank_open[b2x_ba] <= 1'b1;
      if (b2x_fire && state == BK_CLOSE) bank_open <= '0;  // Table cleared
    end
  end

  // --------------------
  // Current access and row table
  always_ff @(posedge clk) begin
    if (b2r_ack) begin
      cur_write <= r2b_write;
      b2x_ba    <= r2b_ba;
      cur_row   <= r2b_row;
      cur_col   <= r2b_col;
      b2x_wdata <= r2b_wdata;
      b2x_mask  <= r2b_mask;
    end
    if (b2x_fire && state == BK_ACT) open_row[b2x_ba] <= cur_row;
  end

endmodule

`default_nettype wire

// File: sdrc_init_rfsh.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module sdrc_init_rfsh import sdrc_pkg::*; (
  input  wire       clk,
  input  wire       arst_n,
  input  wire       x2c_ready,
  input  wire       rfsh_gnt,
  output logic      i2x_valid,
  output sdr_cmd_t  i2x_cmd,
  output sdr_addr_t i2x_addr,
  output logic      rfsh_req,
  output logic      sdr_init_done
);

  localparam int TMR_W = $clog2(`SDR_RFSH_PERIOD);

  init_state_e      state;
  logic [TMR_W-1:0] tmr;       // Power-up wait, then refresh interval
  logic             i2x_fire;

  assign i2x_fire = i2x_valid && x2c_ready;

  always_comb begin
    i2x_valid = 1'b1;
    i2x_cmd   = `CMD_REF;
    i2x_addr  = '0;
    case (state)
      INIT_PRE: begin
        i2x_cmd            = `CMD_PRE;
        i2x_addr[`SDR_A10] = 1'b1;  // Precharge all
      end
      INIT_MRS: begin
        i2x_cmd  = `CMD_MRS;
        i2x_addr = `SDR_MODE_REG;
      end
      INIT_REF1, INIT_REF2, RUN_REF: i2x_cmd = `CMD_REF;
      default: begin                // Waiting or idle
        i2x_valid = 1'b0;
        i2x_cmd   = `CMD_NOP;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state         <= INIT_WAIT;
      tmr           <= '0;
      rfsh_req      <= 1'b0;
      sdr_init_done <= 1'b0;
    end else begin
      if (state == INIT_WAIT) begin
        if (tmr == TMR_W'(`SDR_INIT_WAIT - 1)) begin
          tmr   <= '0;
          state <= INIT_PRE;
        end else tmr <= tmr + 1'b1;
      end else if (sdr_init_done) begin
        if (tmr == TMR_W'(`SDR_RFSH_PERIOD - 1)) begin
          if (!rfsh_req) begin  // Stall at expiry while one is pending
            rfsh_req <= 1'b1;
            tmr      <= '0;
          end
        end else tmr <= tmr + 1'b1;
      end
      case (state)
        INIT_PRE:  if (i2x_fire) state <= INIT_REF1;
        INIT_REF1: if (i2x_fire) state <= INIT_REF2;
        INIT_REF2: if (i2x_fire) state <= INIT_MRS;
        INIT_MRS: if (i2x_fire) begin
          state         <= RUN_IDLE;
          sdr_init_done <= 1'b1;
        end
        RUN_IDLE: if (rfsh_req && rfsh_gnt) state <= RUN_REF;  // Banks closed
        RUN_REF: if (i2x_fire) begin
          rfsh_req <= 1'b0;       // Releases the grant
          state    <= RUN_IDLE;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sdrc_xfr_ctl.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module sdrc_xfr_ctl import sdrc_pkg::*; (
  input  wire            clk,
  input  wire            arst_n,
  input  wire            b2x_valid,
  input  wire sdr_cmd_t  b2x_cmd,
  input  wire bank_t     b2x_ba,
  input  wire sdr_addr_t b2x_addr,
  input  wire sdr_data_t b2x_wdata,
  input  wire sdr_mask_t b2x_mask,
  input  wire            i2x_valid,
  input  wire sdr_cmd_t  i2x_cmd,
  input  wire sdr_addr_t i2x_addr,
  input  wire sdr_data_t sdr_din,
  output logic           x2c_ready,
  output logic           sdr_cke,
  output logic           sdr_cs_n,
  output logic           sdr_ras_n,
  output logic           sdr_cas_n,
  output logic           sdr_we_n,
  output bank_t          sdr_ba,
  output sdr_addr_t      sdr_addr,
  output sdr_mask_t      sdr_dqm,
  output sdr_data_t      sdr_dout,
  output sdr_mask_t      sdr_den_n,
  output sdr_data_t      app_rd_data,
  output logic           app_rd_valid
);

  localparam int SPC_W = $clog2(`SDR_TRFC + 1);

  sdr_cmd_t            cmd_sel;
  logic                cmd_fire;
  logic                pin_rd;    // RD on the pins this cycle
  logic [SPC_W-1:0]    spc_cnt;   // Cycles left before next issue
  logic [SPC_W-1:0]    spc_load;
  logic [`SDR_CAS-1:0] rd_sr;     // Reads in flight

  // Init/refresh and bank side are never valid together
  assign cmd_sel   = i2x_valid ? i2x_cmd : b2x_cmd;
  assign x2c_ready = (spc_cnt == '0);
  assign cmd_fire  = (i2x_valid || b2x_valid) && x2c_ready;
  assign sdr_cke   = 1'b1;  // No power-down
  assign pin_rd    = ({sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n} == `CMD_RD);

  always_comb begin
    case (cmd_sel)
      `CMD_ACT: spc_load = SPC_W'(`SDR_TRCD - 1);
      `CMD_PRE: spc_load = SPC_W'(`SDR_TRP - 1);
      `CMD_REF: spc_load = SPC_W'(`SDR_TRFC - 1);
      `CMD_WR:  spc_load = SPC_W'(`SDR_TWR - 1);
      default:  spc_load = '0;  // RD and MRS
    endcase
  end

  // --------------------
  // Command pins and spacing
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      spc_cnt                                  <= '0;
      {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n} <= `CMD_NOP;
      sdr_ba                                   <= '0;
      sdr_addr                                 <= '0;
      sdr_dqm                                  <= '1;
      sdr_den_n                                <= '1;
    end else begin
      if (cmd_fire) spc_cnt <= spc_load;
      else if (spc_cnt != '0) spc_cnt <= spc_cnt - 1'b1;
      {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n} <= cmd_fire ? cmd_sel : `CMD_NOP;
      if (cmd_fire) begin
        sdr_ba   <= i2x_valid ? bank_t'(0) : b2x_ba;
        sdr_addr <= i2x_valid ? i2x_addr : b2x_addr;
      end
      if (cmd_fire && cmd_sel == `CMD_WR) begin
        sdr_dqm   <= b2x_mask;  // Write byte enables
        sdr_den_n <= '0;
      end else begin
        sdr_dqm   <= (cmd_fire && cmd_sel == `CMD_RD) ? '0 : '1;
        sdr_den_n <= '1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire && cmd_sel == `CMD_WR) sdr_dout <= b2x_wdata;
  end

  // --------------------
  // Read return after CAS latency
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_sr        <= '0;
      app_rd_valid <= 1'b0;
    end else begin
      rd_sr        <= {rd_sr[`SDR_CAS-2:0], pin_rd};
      app_rd_valid <= rd_sr[`SDR_CAS-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_sr[`SDR_CAS-1]) app_rd_data <= sdr_din;  // Sample din at latency
  end

endmodule

`default_nettype wire

// File: sdrc_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module sdrc_core import sdrc_pkg::*; (
  input  wire            clk,
  input  wire            arst_n,
  // --------------------
  // Application side
  input  wire            app_req,
  input  wire app_addr_t app_req_addr,
  input  wire            app_req_wr_n,
  input  wire sdr_data_t app_wr_data,
  input  wire sdr_mask_t app_wr_en_n,
  output logic           app_req_ack,
  output sdr_data_t      app_rd_data,
  output logic           app_rd_valid,
  output logic           sdr_init_done,
  // --------------------
  // SDRAM pins
  output logic           sdr_cke,
  output logic           sdr_cs_n,
  output logic           sdr_ras_n,
  output logic           sdr_cas_n,
  output logic           sdr_we_n,
  output bank_t          sdr_ba,
  output sdr_addr_t      sdr_addr,
  output sdr_mask_t      sdr_dqm,
  output sdr_data_t      sdr_dout,
  output sdr_mask_t      sdr_den_n,
  input  wire sdr_data_t sdr_din
);

  // Request holder to bank scheduler
  logic      r2b_req, r2b_write, b2r_ack;
  bank_t     r2b_ba;
  row_t      r2b_row;
  col_t      r2b_col;
  sdr_data_t r2b_wdata;
  sdr_mask_t r2b_mask;

  // Commands toward the pins
  logic      b2x_valid, i2x_valid, x2c_ready;
  sdr_cmd_t  b2x_cmd, i2x_cmd;
  bank_t     b2x_ba;
  sdr_addr_t b2x_addr, i2x_addr;
  sdr_data_t b2x_wdata;
  sdr_mask_t b2x_mask;
  logic      rfsh_req, rfsh_gnt;  // Refresh handshake

  sdrc_req_gen   u_req_gen   (.*);
  sdrc_bank_ctl  u_bank_ctl  (.*);
  sdrc_init_rfsh u_init_rfsh (.*);
  sdrc_xfr_ctl   u_xfr_ctl   (.*);

endmodule

`default_nettype wire

// File: tb_sdram_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module tb_sdram_model import sdrc_pkg::*; (
  input  wire            clk,
  input  wire            cke,
  input  wire            cs_n,
  input  wire            ras_n,
  input  wire            cas_n,
  input  wire            we_n,
  input  wire bank_t     ba,
  input  wire sdr_addr_t addr,
  input  wire sdr_mask_t dqm,     // High masks a byte lane
  input  wire sdr_mask_t den_n,   // Low where the controller drives a lane
  input  wire sdr_data_t dq_in,   // Write data from the controller
  output sdr_data_t      dq_out   // Read data toward the controller
);

  sdr_data_t mem [app_addr_t];      // Written words only
  row_t      act_row [`SDR_NBANK];  // Row opened by the last ACT
  sdr_data_t rd_pipe [`SDR_CAS];    // Read data on its way out
  sdr_cmd_t  cmd;
  app_addr_t word_addr;

  assign cmd       = {cs_n, ras_n, cas_n, we_n};
  assign word_addr = {ba, act_row[ba], addr[`SDR_COL_W-1:0]};
  assign dq_out    = rd_pipe[`SDR_CAS-1];  // Valid CAS cycles after RD

  // Unwritten words read back a pattern built from every address bit
  function automatic sdr_data_t fetch(app_addr_t a);
    if (mem.exists(a)) return mem[a];
    return a[15:0] ^ {a[21:16], a[9:0]};
  endfunction

  always @(posedge clk) begin
    sdr_data_t w;
    w = fetch(word_addr);
    if (cke && cmd == `CMD_ACT) act_row[ba] <= addr;  // Row opens
    if (cke && cmd == `CMD_WR) begin
      for (int i = 0; i < `SDR_BW; i++) begin
        if (!dqm[i]) w[8*i +: 8] = den_n[i] ? 8'hxx : dq_in[8*i +: 8];  // Undriven lane is x
      end
      mem[word_addr] = w;
    end
    rd_pipe[0] <= (cke && cmd == `CMD_RD) ? fetch(word_addr) : 'x;
    for (int i = 1; i < `SDR_CAS; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

endmodule

`default_nettype wire

// File: sdrc_chk.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module sdrc_chk import sdrc_pkg::*; (
  input wire            clk,
  input wire            arst_n,
  input wire            sdr_init_done,
  input wire            sdr_cs_n,
  input wire            sdr_ras_n,
  input wire            sdr_cas_n,
  input wire            sdr_we_n,
  input wire bank_t     sdr_ba,
  input wire sdr_addr_t sdr_addr,
  input wire            app_req_ack,
  input wire app_addr_t app_req_addr,
  input wire            app_rd_valid
);

  sdr_cmd_t              cmd;
  logic                  is_act, is_pre, is_rd, is_xfr, is_ref;
  logic [2:0]            init_step;            // Next init command expected
  sdr_cmd_t              init_exp;
  logic [`SDR_NBANK-1:0] bank_open;            // Bank state seen on the pins
  row_t                  open_row [`SDR_NBANK];
  sdr_cmd_t              last_cmd;
  int                    since;                // Cycles since last command
  int                    ref_gap;              // Cycles since last periodic REF
  logic                  ref_seen;
  app_addr_t             req_mem [8];          // Accepted requests, oldest first
  logic [2:0]            wp, rp;
  logic [3:0]            q_cnt;
  bank_t                 f_ba;
  row_t                  f_row;
  col_t                  f_col;
  int                    fail_cnt = 0;

  assign cmd    = {sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n};
  assign is_act = (cmd == `CMD_ACT);
  assign is_pre = (cmd == `CMD_PRE);
  assign is_ref = (cmd == `CMD_REF);
  assign is_rd  = (cmd == `CMD_RD);
  assign is_xfr = is_rd || (cmd == `CMD_WR);
  assign {f_ba, f_row, f_col} = req_mem[rp];  // Oldest request split

  always_comb begin
    case (init_step)
      3'd0:    init_exp = `CMD_PRE;
      3'd3:    init_exp = `CMD_MRS;
      default: init_exp = `CMD_REF;  // Two refreshes
    endcase
  end

  function automatic int min_gap(sdr_cmd_t c);
    case (c)
      `CMD_ACT: return `SDR_TRCD;
      `CMD_PRE: return `SDR_TRP;
      `CMD_REF: return `SDR_TRFC;
      `CMD_WR:  return `SDR_TWR;
      default:  return 0;
    endcase
  endfunction

  // --------------------
  // Pin-level bookkeeping
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      init_step <= '0;
      bank_open <= '0;
      last_cmd  <= `CMD_NOP;
      since     <= 0;
      ref_gap   <= 0;
      ref_seen  <= 1'b0;
      wp        <= '0;
      rp        <= '0;
      q_cnt     <= '0;
    end else begin
      if (init_step < 3'd4 && cmd != `CMD_NOP) init_step <= init_step + 1'b1;
      if (is_act) begin
        bank_open[sdr_ba] <= 1'b1;
        open_row[sdr_ba]  <= sdr_addr;
      end
      if (is_pre) begin
        if (sdr_addr[`SDR_A10]) bank_open <= '0;  // All banks
        else bank_open[sdr_ba] <= 1'b0;
      end
      if (cmd != `CMD_NOP) begin
        last_cmd <= cmd;
        since    <= 1;
      end else since <= since + 1;
      if (is_ref && init_step == 3'd4) begin  // Periodic refresh only
        ref_seen <= 1'b1;
        ref_gap  <= 1;
      end else ref_gap <= ref_gap + 1;
      if (app_req_ack) begin
        req_mem[wp] <= app_req_addr;  // Address still held at ack
        wp          <= wp + 1'b1;
      end
      if (is_xfr) rp <= rp + 1'b1;
      q_cnt <= q_cnt + 4'(app_req_ack) - 4'(is_xfr);
    end
  end

  // --------------------
  // Init order
  a_init_order: assert property (@(posedge clk) disable iff (!arst_n)
    (init_step < 3'd4 && cmd != `CMD_NOP) |-> (cmd == init_exp)
      && (!is_pre || sdr_addr[`SDR_A10]) && (cmd != `CMD_MRS || sdr_addr == `SDR_MODE_REG))
    else begin
      $error("init command out of order or with a wrong address");
      fail_cnt++;
    end

  a_no_early_xfr: assert property (@(posedge clk) disable iff (!arst_n)
    (!sdr_init_done || init_step < 3'd4) |-> !is_xfr)
    else begin
      $error("read or write issued before init finished");
      fail_cnt++;
    end

  a_done_at_mrs: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(sdr_init_done) |-> cmd == `CMD_MRS)
    else begin
      $error("init done without mode register load");
      fail_cnt++;
    end

  // Page management against the oldest request
  a_xfr_row: assert property (@(posedge clk) disable iff (!arst_n)
    is_xfr |-> q_cnt != 0 && sdr_ba == f_ba && bank_open[f_ba]
      && open_row[f_ba] == f_row && sdr_addr[`SDR_COL_W-1:0] == f_col)
    else begin
      $error("read or write to a bank without the requested row open");
      fail_cnt++;
    end

  a_act_target: assert property (@(posedge clk) disable iff (!arst_n)
    is_act |-> q_cnt != 0 && !bank_open[sdr_ba] && sdr_ba == f_ba && sdr_addr == f_row)
    else begin
      $error("activate to an open bank or to a row not requested");
      fail_cnt++;
    end

  a_pre_miss: assert property (@(posedge clk) disable iff (!arst_n)
    (is_pre && !sdr_addr[`SDR_A10] && init_step == 3'd4) |-> q_cnt != 0
      && sdr_ba == f_ba && bank_open[f_ba] && open_row[f_ba] != f_row)
    else begin
      $error("bank precharge without a page miss");
      fail_cnt++;
    end

  a_ref_closed: assert property (@(posedge clk) disable iff (!arst_n)
    is_ref |-> bank_open == '0)
    else begin
      $error("refresh with a bank still open");
      fail_cnt++;
    end

  // Spacing and latency
  a_spacing: assert property (@(posedge clk) disable iff (!arst_n)
    (cmd != `CMD_NOP) |-> since >= min_gap(last_cmd))
    else begin
      $error("command issued too soon after the previous one");
      fail_cnt++;
    end

  a_rd_latency: assert property (@(posedge clk) disable iff (!arst_n)
    is_rd |-> ##(`SDR_CAS+1) app_rd_valid)
    else begin
      $error("read data valid missing after read command");
      fail_cnt++;
    end

  a_rd_source: assert property (@(posedge clk) disable iff (!arst_n)
    app_rd_valid |-> $past(is_rd, `SDR_CAS+1))
    else begin
      $error("read data valid without a matching read command");
      fail_cnt++;
    end

  a_ref_interval: assert property (@(posedge clk) disable iff (!arst_n)
    ref_seen |-> ref_gap <= `SDR_RFSH_PERIOD + `SDR_TRFC)
    else begin
      $error("refresh interval exceeded");
      fail_cnt++;
    end

endmodule

bind sdrc_core sdrc_chk u_chk (.*);

`default_nettype wire

// File: tb_sdrc.sv
`timescale 1ns/10ps
`default_nettype none

`include "sdrc_config.svh"

module tb_sdrc import sdrc_pkg::*; ();

  localparam int CLK_PER = 40;
  localparam int N_RT    = 16;              // Round-trip words
  localparam int N_REQ   = 2*N_RT + 20;     // Requests over all tests
  localparam int ACC_CYC = 24;              // Worst cycles per request
  localparam int WD_CYC  = `SDR_INIT_WAIT + 64 + N_REQ*ACC_CYC + 4*`SDR_RFSH_PERIOD;

  logic      clk, arst_n;
  logic      app_req, app_req_wr_n, app_req_ack, app_rd_valid, sdr_init_done;
  app_addr_t app_req_addr;
  sdr_data_t app_wr_data, app_rd_data, sdr_dout, sdr_din;
  sdr_mask_t app_wr_en_n, sdr_dqm, sdr_den_n;
  logic      sdr_cke, sdr_cs_n, sdr_ras_n, sdr_cas_n, sdr_we_n;
  bank_t     sdr_ba;
  sdr_addr_t sdr_addr;

  sdr_data_t ref_mem [app_addr_t];  // Expected memory contents
  sdr_data_t exp_q [$];             // Reads in flight, oldest first
  app_addr_t addr_list [N_RT];
  integer    seed = 32'h3c43;
  int        err_cnt, rd_cnt, n_tests, err_mark;

  sdrc_core dut0 (.*);

  tb_sdram_model u_mem (
    .clk    (clk),
    .cke    (sdr_cke),
    .cs_n   (sdr_cs_n),
    .ras_n  (sdr_ras_n),
    .cas_n  (sdr_cas_n),
    .we_n   (sdr_we_n),
    .ba     (sdr_ba),
    .addr   (sdr_addr),
    .dqm    (sdr_dqm),
    .den_n  (sdr_den_n),
    .dq_in  (sdr_dout),
    .dq_out (sdr_din)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PER/2) clk = ~clk;
  end

  // --------------------
  // Helpers
  function automatic sdr_data_t merge_bytes(sdr_data_t old_w, sdr_data_t new_w,
                                            sdr_mask_t en_n);
    sdr_data_t res;
    res = old_w;
    for (int i = 0; i < `SDR_BW; i++) begin
      if (!en_n[i]) res[8*i +: 8] = new_w[8*i +: 8];  // Enabled lane takes new byte
    end
    return res;
  endfunction

  function automatic int total_errs();
    return err_cnt + dut0.u_chk.fail_cnt;  // Scoreboard plus bound checker
  endfunction

  task automatic send_req(input logic wr, input app_addr_t addr,
                          input sdr_data_t data, input sdr_mask_t en_n);
    int wait_cyc;
    if (wr) ref_mem[addr] = merge_bytes(ref_mem.exists(addr) ? ref_mem[addr] : '0, data, en_n);
    else exp_q.push_back(ref_mem[addr]);  // Expected before the request goes out
    app_req      = 1'b1;
    app_req_wr_n = !wr;
    app_req_addr = addr;
    app_wr_data  = data;
    app_wr_en_n  = en_n;
    wait_cyc     = 0;
    do begin
      @(posedge clk);
      #2;
      wait_cyc++;
    end while (!app_req_ack && wait_cyc < 100);
    if (!app_req_ack) begin
      $display("Request to address %h was not acknowledged within 100 cycles", addr);
      err_cnt++;
    end
    @(posedge clk);  // Ack sampled on this edge
    #2;
    app_req = 1'b0;
  endtask

  task automatic drain_reads();
    int wait_cyc;
    wait_cyc = 0;
    while (exp_q.size() != 0 && wait_cyc < 100) begin
      @(posedge clk);
      #2;
      wait_cyc++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d reads never returned data", exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = total_errs() - err_mark;
    $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    err_mark = total_errs();
    n_tests++;
  endtask

  // --------------------
  // Read-data scoreboard, sampled mid-cycle
  always @(negedge clk) begin
    if (arst_n && app_rd_valid) begin
      if (exp_q.size() == 0) begin
        $display("Read data returned at %0t ns with no read pending", $time);
        err_cnt++;
      end else begin
        rd_cnt++;
        assert (app_rd_data === exp_q[0])
        else begin
          $display("Error at %0t ns: app_rd_data expected %h, got %h",
                   $time, exp_q[0], app_rd_data);
          err_cnt++;
        end
        void'(exp_q.pop_front());
      end
    end
  end

  // --------------------
  // Stimulus
  initial begin
    int        wait_cyc;
    app_addr_t a;
    app_req      = 1'b0;
    app_req_addr = '0;
    app_req_wr_n = 1'b1;
    app_wr_data  = '0;
    app_wr_en_n  = '0;
    err_cnt      = 0;
    rd_cnt       = 0;
    n_tests      = 0;
    err_mark     = 0;
    arst_n       = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;

    wait_cyc = 0;  // Power-up sequence
    while (!sdr_init_done && wait_cyc < `SDR_INIT_WAIT + 100) begin
      @(posedge clk);
      #2;
      wait_cyc++;
    end
    if (!sdr_init_done) begin
      $display("Init sequence did not finish in %0d cycles", wait_cyc);
      err_cnt++;
    end
    end_test("init");

    for (int i = 0; i < N_RT; i++) begin  // Random writes then reads
      addr_list[i] = app_addr_t'($random(seed));
      send_req(1'b1, addr_list[i], sdr_data_t'($random(seed)), 2'b00);
    end
    for (int i = 0; i < N_RT; i++) begin
      send_req(1'b0, addr_list[i], '0, 2'b00);
    end
    drain_reads();
    end_test("round_trip");

    a = {2'd2, 12'h0a5, 8'h40};
    send_req(1'b1, a, 16'h1234, 2'b00);
    send_req(1'b1, a, 16'habcd, 2'b10);  // Upper byte kept
    send_req(1'b0, a, '0, 2'b00);
    send_req(1'b1, a, 16'h5aef, 2'b01);  // Lower byte kept
    send_req(1'b0, a, '0, 2'b00);
    drain_reads();
    end_test("byte_mask");

    send_req(1'b1, {2'd1, 12'd5, 8'd3}, 16'h0503, 2'b00);
    send_req(1'b1, {2'd1, 12'd5, 8'd9}, 16'h0509, 2'b00);  // Page hit
    send_req(1'b0, {2'd1, 12'd5, 8'd3}, '0, 2'b00);
    send_req(1'b1, {2'd1, 12'd6, 8'd3}, 16'h0603, 2'b00);  // Miss in open bank
    send_req(1'b0, {2'd1, 12'd5, 8'd9}, '0, 2'b00);
    send_req(1'b1, {2'd3, 12'd6, 8'd3}, 16'h3603, 2'b00);  // Another bank
    send_req(1'b0, {2'd1, 12'd6, 8'd3}, '0, 2'b00);
    drain_reads();
    end_test("page_mgmt");

    for (int i = 0; i < 4; i++) begin  // Data kept across idle refreshes
      addr_list[i] = app_addr_t'($random(seed));
      send_req(1'b1, addr_list[i], sdr_data_t'($random(seed)), 2'b00);
    end
    repeat (3*`SDR_RFSH_PERIOD) @(posedge clk);
    #2;
    for (int i = 0; i < 4; i++) begin
      send_req(1'b0, addr_list[i], '0, 2'b00);
    end
    drain_reads();
    end_test("refresh");

    $display("tests %0d, reads checked %0d, errors %0d", n_tests, rd_cnt, total_errs());
    if (total_errs() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog sized from the test lengths
  initial begin
    repeat (16 + WD_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish", 16 + WD_CYC);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
sdrc_pkg.sv
sdrc_req_gen.sv
sdrc_bank_ctl.sv
sdrc_init_rfsh.sv
sdrc_xfr_ctl.sv
sdrc_core.sv
tb_sdram_model.sv
sdrc_chk.sv
tb_sdrc.sv

// File: Bender.yml
package:
  name: sdrc

sources:
  - include_dirs:
      - .
    files:
      - sdrc_pkg.sv
      - sdrc_req_gen.sv
      - sdrc_bank_ctl.sv
      - sdrc_init_rfsh.sv
      - sdrc_xfr_ctl.sv
      - sdrc_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sdram_model.sv
      - sdrc_chk.sv
      - tb_sdrc.sv
